//--- verilog/txe_config.svh
// sizes and widths of the RDMA transmit engine, included by every file that needs them
`ifndef TXE_CONFIG_SVH
`define TXE_CONFIG_SVH

// largest DMA read issued for one segment, in bytes
`define TXE_PKT_LEN 1024

`define TXE_WQE_INDEX_W 4
`define TXE_RAM_ADDR_W 16
`define TXE_DMA_ADDR_W 64
`define TXE_DMA_LEN_W 20
`define TXE_WQE_LEN_W 32
`define TXE_QPN_W 24
`define TXE_SEQ_W 24

// msn counters, picked by the low source qpn bits
`define TXE_MSN_BUCKETS 16
`define TXE_CPL_FIFO_DEPTH 16

`endif

//--- verilog/txe_pkg.sv
// shared types of the transmit engine, pulled into each module by a wildcard import
`default_nettype none

`include "txe_config.svh"

package txe_pkg;

    typedef logic [`TXE_WQE_INDEX_W-1:0] wqe_index_t;
    typedef logic [`TXE_QPN_W-1:0]       qpn_t;
    typedef logic [`TXE_SEQ_W-1:0]       seq_t;
    typedef logic [`TXE_RAM_ADDR_W-1:0]  ram_addr_t;
    typedef logic [`TXE_DMA_ADDR_W-1:0]  dma_addr_t;
    typedef logic [`TXE_DMA_LEN_W-1:0]   dma_len_t;
    typedef logic [`TXE_WQE_LEN_W-1:0]   wqe_len_t;

    // one read from host memory into the on-board ram
    typedef struct packed {
        dma_addr_t  dma_addr;
        ram_addr_t  ram_addr;
        dma_len_t   len;
        wqe_index_t tag;
    } dma_req_t;

    typedef struct packed {
        wqe_len_t  len;
        dma_addr_t laddr;
        dma_addr_t raddr;
        qpn_t      dst_qpn;
        qpn_t      src_qpn;
    } wqe_entry_t;

    // one segment ready to go out of the ram
    typedef struct packed {
        ram_addr_t  addr;
        dma_len_t   len;
        wqe_index_t tag;
        dma_addr_t  raddr;
        seq_t       psn;
        seq_t       msn;
        qpn_t       dst_qpn;
        qpn_t       src_qpn;
        logic       last;
    } tx_desc_t;

endpackage

`default_nettype wire

//--- verilog/skid_buffer.sv
// registered valid/ready slice with a spare entry, placed in front of each output stream
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t temp_data;
    logic     temp_valid;
    logic     out_valid_next;
    logic     temp_valid_next;
    logic     in_ready_next;
    logic     store_in_to_out;
    logic     store_in_to_temp;
    logic     store_temp_to_out;

    // stay ready unless the spare entry would fill
    assign in_ready_next = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            in_ready   <= in_ready_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_data <= in_data;
        end else if (store_temp_to_out) begin
            out_data <= temp_data;
        end
        if (store_in_to_temp) begin
            temp_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wqe_table.sv
// descriptor table with psn and msn tracking, shared by the segmenter and the scheduler
`default_nettype none

`include "txe_config.svh"

interface desc_table_if import txe_pkg::*; ();

    logic       wr_en;
    wqe_index_t wr_index;
    wqe_entry_t wr_entry;
    wqe_index_t rd_index;
    logic       adv_en;
    wqe_entry_t rd_entry;
    seq_t       rd_psn;
    seq_t       rd_msn;

    modport writer (
        output wr_en, wr_index, wr_entry
    );

    modport reader (
        output rd_index, adv_en,
        input  rd_entry, rd_psn, rd_msn
    );

    modport table_side (
        input  wr_en, wr_index, wr_entry, rd_index, adv_en,
        output rd_entry, rd_psn, rd_msn
    );

endinterface

module wqe_table import txe_pkg::*; (
    input logic               clk,
    input logic               rst,
    desc_table_if.table_side  tbl
);

    localparam int DEPTH    = 2 ** `TXE_WQE_INDEX_W;
    localparam int BUCKET_W = $clog2(`TXE_MSN_BUCKETS);

    wqe_entry_t          entry_mem [DEPTH];
    seq_t                psn_mem [DEPTH];
    seq_t                msn_mem [DEPTH];
    seq_t                msn_cnt [`TXE_MSN_BUCKETS];
    logic [BUCKET_W-1:0] wr_bucket;

    assign wr_bucket = tbl.wr_entry.src_qpn[BUCKET_W-1:0];

    // every written wqe uses up one message number of its bucket
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TXE_MSN_BUCKETS; i++) begin
                msn_cnt[i] <= '0;
            end
        end else if (tbl.wr_en) begin
            msn_cnt[wr_bucket] <= msn_cnt[wr_bucket] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tbl.adv_en) begin
            psn_mem[tbl.rd_index] <= psn_mem[tbl.rd_index] + 1'b1;
        end
        // a new wqe restarts its psn, even over a pending advance
        if (tbl.wr_en) begin
            entry_mem[tbl.wr_index] <= tbl.wr_entry;
            psn_mem[tbl.wr_index]   <= '0;
            msn_mem[tbl.wr_index]   <= msn_cnt[wr_bucket];
        end
    end

    assign tbl.rd_entry = entry_mem[tbl.rd_index];
    assign tbl.rd_psn   = psn_mem[tbl.rd_index];
    assign tbl.rd_msn   = msn_mem[tbl.rd_index];

endmodule

`default_nettype wire

//--- verilog/dma_segmenter.sv
// splits each accepted wqe into dma reads of at most one packet into the circular ram
`default_nettype none

`include "txe_config.svh"

module dma_segmenter import txe_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  wqe_entry_t          wqe_entry,
    input  wqe_index_t          wqe_id,
    input  logic                wqe_valid,
    output logic                wqe_ready,
    output dma_req_t            req,
    output logic                req_valid,
    input  logic                req_ready,
    desc_table_if.writer        tbl
);

    localparam wqe_len_t PKT_LEN = wqe_len_t'(`TXE_PKT_LEN);

    // continuation of the wqe being cut up
    logic       active;
    dma_addr_t  next_addr;
    wqe_len_t   rem_len;
    wqe_index_t cur_tag;
    ram_addr_t  wr_ptr;

    logic       wqe_take;
    wqe_len_t   first_len;
    wqe_len_t   cont_len;
    wqe_len_t   seg_len;

    assign wqe_ready = !active && req_ready;
    assign wqe_take  = wqe_valid && wqe_ready;

    assign first_len = (wqe_entry.len > PKT_LEN) ? PKT_LEN : wqe_entry.len;
    assign cont_len  = (rem_len > PKT_LEN) ? PKT_LEN : rem_len;

    always_comb begin
        if (active) begin
            seg_len      = cont_len;
            req.dma_addr = next_addr;
            req.tag      = cur_tag;
        end else begin
            seg_len      = first_len;
            req.dma_addr = wqe_entry.laddr;
            req.tag      = wqe_id;
        end
        req.ram_addr = wr_ptr;
        req.len      = dma_len_t'(seg_len);
        // zero length wqe only lands in the table
        req_valid    = active || (wqe_take && first_len != '0);
    end

    assign tbl.wr_en    = wqe_take;
    assign tbl.wr_index = wqe_id;
    assign tbl.wr_entry = wqe_entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            wr_ptr <= '0;
        end else begin
            if (req_valid && req_ready) begin
                wr_ptr <= wr_ptr + ram_addr_t'(seg_len);
            end
            if (wqe_take && wqe_entry.len > PKT_LEN) begin
                active <= 1'b1;
            end else if (active && req_ready && rem_len <= PKT_LEN) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wqe_take) begin
            next_addr <= wqe_entry.laddr + dma_addr_t'(PKT_LEN);
            rem_len   <= wqe_entry.len - first_len;
            cur_tag   <= wqe_id;
        end else if (active && req_ready) begin
            next_addr <= next_addr + dma_addr_t'(PKT_LEN);
            rem_len   <= rem_len - cont_len;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tx_scheduler.sv
// queues dma completions and turns each one into a transmit descriptor
`default_nettype none

`include "txe_config.svh"

module tx_scheduler import txe_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  wqe_index_t          status_tag,
    input  logic                status_valid,
    output tx_desc_t            desc,
    output logic                desc_valid,
    input  logic                desc_ready,
    desc_table_if.reader        tbl
);

    localparam wqe_len_t PKT_LEN = wqe_len_t'(`TXE_PKT_LEN);
    localparam int       PTR_W   = $clog2(`TXE_CPL_FIFO_DEPTH);

    wqe_index_t       fifo_mem [`TXE_CPL_FIFO_DEPTH];
    logic [PTR_W:0]   fifo_wr;
    logic [PTR_W:0]   fifo_rd;
    logic             fifo_empty;
    logic             fifo_full;
    logic             pop;
    wqe_index_t       head_tag;
    ram_addr_t        rd_ptr;
    wqe_len_t         sent_len;
    wqe_len_t         rest_len;
    wqe_len_t         seg_len;

    assign fifo_empty = fifo_wr == fifo_rd;
    assign fifo_full  = (fifo_wr[PTR_W] != fifo_rd[PTR_W]) &&
                        (fifo_wr[PTR_W-1:0] == fifo_rd[PTR_W-1:0]);
    assign head_tag   = fifo_mem[fifo_rd[PTR_W-1:0]];

    assign desc_valid = !fifo_empty;
    assign pop        = desc_valid && desc_ready;

    assign tbl.rd_index = head_tag;
    assign tbl.adv_en   = pop;

    // segment k of the head wqe, k taken from its psn
    assign sent_len = wqe_len_t'(tbl.rd_psn) * PKT_LEN;
    assign rest_len = tbl.rd_entry.len - sent_len;
    assign seg_len  = (rest_len > PKT_LEN) ? PKT_LEN : rest_len;

    always_comb begin
        desc.addr    = rd_ptr;
        desc.len     = dma_len_t'(seg_len);
        desc.tag     = head_tag;
        desc.raddr   = tbl.rd_entry.raddr;
        desc.psn     = tbl.rd_psn;
        desc.msn     = tbl.rd_msn;
        desc.dst_qpn = tbl.rd_entry.dst_qpn;
        desc.src_qpn = tbl.rd_entry.src_qpn;
        desc.last    = rest_len <= PKT_LEN;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fifo_wr <= '0;
            fifo_rd <= '0;
            rd_ptr  <= '0;
        end else begin
            // no ready on the status strobe, overflow is dropped
            if (status_valid && !fifo_full) begin
                fifo_wr <= fifo_wr + 1'b1;
            end
            if (pop) begin
                fifo_rd <= fifo_rd + 1'b1;
                rd_ptr  <= rd_ptr + ram_addr_t'(seg_len);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (status_valid && !fifo_full) begin
            fifo_mem[fifo_wr[PTR_W-1:0]] <= status_tag;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tx_engine.sv
// top of the RDMA transmit engine, maps the plain stream ports onto the internal blocks
`default_nettype none

`include "txe_config.svh"

module tx_engine import txe_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    input  logic [`TXE_WQE_LEN_W-1:0]   wqe_len,
    input  logic [`TXE_DMA_ADDR_W-1:0]  wqe_laddr,
    input  logic [`TXE_DMA_ADDR_W-1:0]  wqe_raddr,
    input  logic [`TXE_QPN_W-1:0]       wqe_dst_qpn,
    input  logic [`TXE_QPN_W-1:0]       wqe_src_qpn,
    input  logic [`TXE_WQE_INDEX_W-1:0] wqe_id,
    input  logic                        wqe_valid,
    output logic                        wqe_ready,

    output logic [`TXE_DMA_ADDR_W-1:0]  dma_req_dma_addr,
    output logic [`TXE_RAM_ADDR_W-1:0]  dma_req_ram_addr,
    output logic [`TXE_DMA_LEN_W-1:0]   dma_req_len,
    output logic [`TXE_WQE_INDEX_W-1:0] dma_req_tag,
    output logic                        dma_req_valid,
    input  logic                        dma_req_ready,

    input  logic [`TXE_WQE_INDEX_W-1:0] dma_status_tag,
    input  logic                        dma_status_valid,

    output logic [`TXE_RAM_ADDR_W-1:0]  tx_addr,
    output logic [`TXE_DMA_LEN_W-1:0]   tx_len,
    output logic [`TXE_WQE_INDEX_W-1:0] tx_tag,
    output logic [`TXE_DMA_ADDR_W-1:0]  tx_raddr,
    output logic [`TXE_SEQ_W-1:0]       tx_psn,
    output logic [`TXE_SEQ_W-1:0]       tx_msn,
    output logic [`TXE_QPN_W-1:0]       tx_dst_qpn,
    output logic [`TXE_QPN_W-1:0]       tx_src_qpn,
    output logic                        tx_last,
    output logic                        tx_valid,
    input  logic                        tx_ready
);

    wqe_entry_t wqe_entry;
    dma_req_t   seg_req;
    logic       seg_req_valid;
    logic       seg_req_ready;
    dma_req_t   dma_req_out;
    tx_desc_t   sched_desc;
    logic       sched_desc_valid;
    logic       sched_desc_ready;
    tx_desc_t   tx_desc_out;

    desc_table_if tbl_if ();

    assign wqe_entry.len     = wqe_len;
    assign wqe_entry.laddr   = wqe_laddr;
    assign wqe_entry.raddr   = wqe_raddr;
    assign wqe_entry.dst_qpn = wqe_dst_qpn;
    assign wqe_entry.src_qpn = wqe_src_qpn;

    wqe_table table_i (
        .clk (clk),
        .rst (rst),
        .tbl (tbl_if)
    );

    dma_segmenter segmenter_i (
        .clk       (clk),
        .rst       (rst),
        .wqe_entry (wqe_entry),
        .wqe_id    (wqe_id),
        .wqe_valid (wqe_valid),
        .wqe_ready (wqe_ready),
        .req       (seg_req),
        .req_valid (seg_req_valid),
        .req_ready (seg_req_ready),
        .tbl       (tbl_if)
    );

    skid_buffer #(.payload_t(dma_req_t)) dma_skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (seg_req),
        .in_valid  (seg_req_valid),
        .in_ready  (seg_req_ready),
        .out_data  (dma_req_out),
        .out_valid (dma_req_valid),
        .out_ready (dma_req_ready)
    );

    tx_scheduler scheduler_i (
        .clk          (clk),
        .rst          (rst),
        .status_tag   (dma_status_tag),
        .status_valid (dma_status_valid),
        .desc         (sched_desc),
        .desc_valid   (sched_desc_valid),
        .desc_ready   (sched_desc_ready),
        .tbl          (tbl_if)
    );

    skid_buffer #(.payload_t(tx_desc_t)) tx_skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (sched_desc),
        .in_valid  (sched_desc_valid),
        .in_ready  (sched_desc_ready),
        .out_data  (tx_desc_out),
        .out_valid (tx_valid),
        .out_ready (tx_ready)
    );

    assign dma_req_dma_addr = dma_req_out.dma_addr;
    assign dma_req_ram_addr = dma_req_out.ram_addr;
    assign dma_req_len      = dma_req_out.len;
    assign dma_req_tag      = dma_req_out.tag;

    assign tx_addr    = tx_desc_out.addr;
    assign tx_len     = tx_desc_out.len;
    assign tx_tag     = tx_desc_out.tag;
    assign tx_raddr   = tx_desc_out.raddr;
    assign tx_psn     = tx_desc_out.psn;
    assign tx_msn     = tx_desc_out.msn;
    assign tx_dst_qpn = tx_desc_out.dst_qpn;
    assign tx_src_qpn = tx_desc_out.src_qpn;
    assign tx_last    = tx_desc_out.last;

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// clock and reset source for the transmit engine testbench, 100 ns period
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for four rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- test/tx_engine_tb.sv
// testbench of the transmit engine with a DMA model, reference queues and assertion checks
`default_nettype none

`include "txe_config.svh"

module tx_engine_tb import txe_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PKT      = `TXE_PKT_LEN;
    localparam int WAIT_MAX = 5000;

    logic       clk;
    logic       rst;
    wqe_len_t   wqe_len;
    dma_addr_t  wqe_laddr;
    dma_addr_t  wqe_raddr;
    qpn_t       wqe_dst_qpn;
    qpn_t       wqe_src_qpn;
    wqe_index_t wqe_id;
    logic       wqe_valid;
    logic       wqe_ready;
    dma_addr_t  dma_req_dma_addr;
    ram_addr_t  dma_req_ram_addr;
    dma_len_t   dma_req_len;
    wqe_index_t dma_req_tag;
    logic       dma_req_valid;
    logic       dma_req_ready;
    wqe_index_t dma_status_tag;
    logic       dma_status_valid;
    ram_addr_t  tx_addr;
    dma_len_t   tx_len;
    wqe_index_t tx_tag;
    dma_addr_t  tx_raddr;
    seq_t       tx_psn;
    seq_t       tx_msn;
    qpn_t       tx_dst_qpn;
    qpn_t       tx_src_qpn;
    logic       tx_last;
    logic       tx_valid;
    logic       tx_ready;

    // reference model state
    dma_req_t   exp_req[$];
    tx_desc_t   exp_desc[$];
    wqe_index_t cpl_q[$];
    ram_addr_t  model_wr_ptr = '0;
    seq_t       bucket_msn[`TXE_MSN_BUCKETS] = '{default: '0};
    int         pend[2 ** `TXE_WQE_INDEX_W] = '{default: 0};
    int         sent_cnt = 0;
    int         seen_cnt = 0;
    int         mismatch_cnt = 0;
    int         error_cnt = 0;
    logic       bp_mode = 1'b0;
    logic [31:0] rnd_wqe;
    logic [31:0] rnd_bus;
    string      test_name = "reset";

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    tx_engine dut_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp == act) else begin
            $display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            mismatch_cnt++;
        end
    endtask

    // segment k covers bytes k*PKT up to the end of the wqe
    task automatic expect_wqe(input wqe_index_t id, input wqe_len_t len, input dma_addr_t laddr,
                              input dma_addr_t raddr, input qpn_t dst, input qpn_t src);
        dma_req_t r;
        tx_desc_t d;
        wqe_len_t done;
        wqe_len_t seg;
        int       k;
        done = '0;
        k = 0;
        while (done < len) begin
            seg = (len - done > PKT) ? PKT : len - done;
            r.dma_addr = laddr + dma_addr_t'(done);
            r.ram_addr = model_wr_ptr;
            r.len      = dma_len_t'(seg);
            r.tag      = id;
            exp_req.push_back(r);
            d.addr     = model_wr_ptr;
            d.len      = dma_len_t'(seg);
            d.tag      = id;
            d.raddr    = raddr;
            d.psn      = seq_t'(k);
            d.msn      = bucket_msn[src[3:0]];
            d.dst_qpn  = dst;
            d.src_qpn  = src;
            d.last     = (done + PKT >= len);
            exp_desc.push_back(d);
            model_wr_ptr = model_wr_ptr + ram_addr_t'(seg);
            done = done + seg;
            k++;
            pend[id]++;
        end
        bucket_msn[src[3:0]] = bucket_msn[src[3:0]] + 1'b1;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_wqe(input wqe_index_t id, input wqe_len_t len, input dma_addr_t laddr,
                            input dma_addr_t raddr, input qpn_t dst, input qpn_t src);
        int t;
        t = 0;
        while (pend[id] != 0 && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (pend[id] != 0) begin
            $display("%s: wqe id %0h still had descriptors outstanding", test_name, id);
            error_cnt++;
        end
        wqe_id      = id;
        wqe_len     = len;
        wqe_laddr   = laddr;
        wqe_raddr   = raddr;
        wqe_dst_qpn = dst;
        wqe_src_qpn = src;
        wqe_valid   = 1'b1;
        t = 0;
        @(posedge clk);
        while (!wqe_ready && t < WAIT_MAX) begin
            @(posedge clk);
            t++;
        end
        if (wqe_ready) begin
            expect_wqe(id, len, laddr, raddr, dst, src);
        end else begin
            $display("%s: the engine never accepted wqe id %0h", test_name, id);
            error_cnt++;
        end
        @(negedge clk);
        wqe_valid = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while ((exp_req.size() != 0 || exp_desc.size() != 0) && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (exp_req.size() != 0 || exp_desc.size() != 0) begin
            $display("%s: %0d requests and %0d descriptors never came out", test_name,
                     exp_req.size(), exp_desc.size());
            error_cnt++;
        end
    endtask

    // request monitor feeding the completion queue of the DMA model
    always @(posedge clk) begin : req_monitor
        dma_req_t r;
        if (!rst && dma_req_valid && dma_req_ready) begin
            if (exp_req.size() == 0) begin
                $display("%s: DMA request with tag %0h was not expected", test_name, dma_req_tag);
                error_cnt++;
            end else begin
                r = exp_req.pop_front();
                check_value("dma_addr", r.dma_addr, dma_req_dma_addr);
                check_value("ram_addr", 64'(r.ram_addr), 64'(dma_req_ram_addr));
                check_value("dma_len", 64'(r.len), 64'(dma_req_len));
                check_value("dma_tag", 64'(r.tag), 64'(dma_req_tag));
            end
            cpl_q.push_back(dma_req_tag);
        end
    end

    always @(posedge clk) begin : tx_monitor
        tx_desc_t d;
        if (!rst && tx_valid && tx_ready) begin
            if (exp_desc.size() == 0) begin
                $display("%s: descriptor with tag %0h was not expected", test_name, tx_tag);
                error_cnt++;
            end else begin
                d = exp_desc.pop_front();
                check_value("tx_addr", 64'(d.addr), 64'(tx_addr));
                check_value("tx_len", 64'(d.len), 64'(tx_len));
                check_value("tx_tag", 64'(d.tag), 64'(tx_tag));
                check_value("tx_raddr", d.raddr, tx_raddr);
                check_value("tx_psn", 64'(d.psn), 64'(tx_psn));
                check_value("tx_msn", 64'(d.msn), 64'(tx_msn));
                check_value("tx_dst_qpn", 64'(d.dst_qpn), 64'(tx_dst_qpn));
                check_value("tx_src_qpn", 64'(d.src_qpn), 64'(tx_src_qpn));
                check_value("tx_last", 64'(d.last), 64'(tx_last));
                pend[d.tag]--;
            end
            seen_cnt++;
        end
    end

    // DMA model and output sink with completions in request order
    initial begin : bus_model
        int cpl_wait;
        cpl_wait = 0;
        forever begin
            @(negedge clk);
            rnd_bus = xorshift(rnd_bus);
            dma_req_ready = bp_mode ? rnd_bus[0] : 1'b1;
            tx_ready      = bp_mode ? rnd_bus[8] : 1'b1;
            dma_status_valid = 1'b0;
            if (cpl_wait > 0) begin
                cpl_wait--;
            end else if (cpl_q.size() > 0 && sent_cnt - seen_cnt < 8) begin
                dma_status_tag   = cpl_q.pop_front();
                dma_status_valid = 1'b1;
                sent_cnt++;
                cpl_wait = int'(rnd_bus[17:16]);
            end
        end
    end

    initial begin : main
        int t;
        wqe_len_t len;
        wqe_len = '0;
        wqe_laddr = '0;
        wqe_raddr = '0;
        wqe_dst_qpn = '0;
        wqe_src_qpn = '0;
        wqe_id = '0;
        wqe_valid = 1'b0;
        dma_req_ready = 1'b0;
        dma_status_tag = '0;
        dma_status_valid = 1'b0;
        tx_ready = 1'b0;
        rnd_wqe = 32'h28c7;
        rnd_bus = xorshift(32'h28c7);

        t = 0;
        @(posedge clk);
        while (rst && t < 20) begin
            @(posedge clk);
            t++;
            assert (!dma_req_valid && !tx_valid && !wqe_ready) else begin
                $display("reset: a valid output or wqe_ready was high under reset");
                error_cnt++;
            end
        end
        if (rst) begin
            $display("reset: reset was still asserted after 20 cycles");
            error_cnt++;
        end
        @(posedge clk);
        assert (!dma_req_valid && !tx_valid) else begin
            $display("reset: a valid output was high on the first edge after reset");
            error_cnt++;
        end
        t = 0;
        while (!wqe_ready && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (!wqe_ready) begin
            $display("reset: wqe_ready never went high after reset");
            error_cnt++;
        end
        @(negedge clk);

        // the 62000 byte wqe carries the ram pointer past 2^16
        test_name = "segmentation";
        send_wqe(4'd0, 32'd1, 64'h10_0000_0000, 64'ha0_0000_0000, 24'h000a00, 24'h000100);
        send_wqe(4'd1, 32'd1024, 64'h11_0000_0400, 64'ha1_0000_0000, 24'h000a01, 24'h000101);
        send_wqe(4'd2, 32'd1025, 64'h12_0000_0000, 64'ha2_0000_0000, 24'h000a02, 24'h000102);
        send_wqe(4'd3, 32'd3000, 64'h13_0000_0000, 64'ha3_0000_0000, 24'h000a03, 24'h000103);
        send_wqe(4'd4, 32'd62000, 64'h14_0000_0000, 64'ha4_0000_0000, 24'h000a04, 24'h000104);
        drain();

        test_name = "msn_buckets";
        send_wqe(4'd5, 32'd2048, 64'h20_0000_0000, 64'hb0_0000_0000, 24'h000b00, 24'h000209);
        send_wqe(4'd6, 32'd100, 64'h21_0000_0000, 64'hb1_0000_0000, 24'h000b01, 24'h000319);
        send_wqe(4'd7, 32'd500, 64'h22_0000_0000, 64'hb2_0000_0000, 24'h000b02, 24'h00000a);
        send_wqe(4'd8, 32'd0, 64'h23_0000_0000, 64'hb3_0000_0000, 24'h000b03, 24'h000429);
        send_wqe(4'd9, 32'd1500, 64'h24_0000_0000, 64'hb4_0000_0000, 24'h000b04, 24'h000539);
        drain();

        test_name = "back_pressure";
        @(posedge clk);
        bp_mode = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 40; i++) begin
            rnd_wqe = xorshift(rnd_wqe);
            len = wqe_len_t'(rnd_wqe[12:0]);
            rnd_wqe = xorshift(rnd_wqe);
            send_wqe(wqe_index_t'(i), len, {32'h0, rnd_wqe}, {rnd_wqe, 32'h1000},
                     rnd_wqe[31:8], rnd_wqe[23:0]);
        end
        drain();

        $display("closing: %0d mismatches, %0d other errors", mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/txe_pkg.sv
verilog/skid_buffer.sv
verilog/wqe_table.sv
verilog/dma_segmenter.sv
verilog/tx_scheduler.sv
verilog/tx_engine.sv
test/tb_clock.sv
test/tx_engine_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f tb.f --top-module tx_engine_tb -o tx_engine_sim

./obj_dir/tx_engine_sim > sim.log
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
